/* verilog/i2c_tti_pkg.sv */
// Bus event, queue descriptor and response status types with the shared widths
package i2c_tti_pkg;

  // Queue data width and descriptor field widths
  parameter int DwordWidth = 32;
  parameter int LenWidth   = 16;
  parameter int TidWidth   = 4;

  // Event kinds reported by the bus-side target engine
  typedef enum logic [2:0] {
    AcqStart   = 3'd0,
    AcqRestart = 3'd1,
    AcqData    = 3'd2,
    AcqStop    = 3'd3,
    AcqNack    = 3'd4
  } acq_id_e;

  // One bus event
  // For START and restart, data[0] is the R/W bit and 1 means read
  typedef struct packed {
    acq_id_e    id;
    logic [7:0] data;
  } acq_evt_t;

  // Command descriptor from the host with the read length
  typedef struct packed {
    logic [TidWidth-1:0] tid;
    logic [LenWidth-1:0] data_length;
  } cmd_desc_t;

  // Response status
  typedef enum logic {
    RespSuccess = 1'b0,
    RespAborted = 1'b1
  } resp_err_e;

  // Response descriptor toward the host
  // data_length carries the number of bytes moved on the bus
  typedef struct packed {
    resp_err_e           err_status;
    logic [TidWidth-1:0] tid;
    logic [LenWidth-1:0] data_length;
  } resp_desc_t;

endpackage

/* verilog/tti_queue.sv */
// Synchronous circular-buffer FIFO with valid/ready on push and pop sides
module tti_queue #(
  parameter int Width = 32,
  parameter int Depth = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_valid_i,
  input  logic [Width-1:0] push_data_i,
  output logic             push_ready_o,
  output logic             pop_valid_o,
  output logic [Width-1:0] pop_data_o,
  input  logic             pop_ready_i
);

  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth = $clog2(Depth + 1);

  logic [Width-1:0]    mem_q [Depth];
  logic [PtrWidth-1:0] wptr_q, rptr_q;
  logic [CntWidth-1:0] count_q;
  logic                live_q;
  logic                push, pop;

  // Ready stays low in the first cycle out of reset
  assign push_ready_o = live_q & (count_q != CntWidth'(Depth));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
      live_q  <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (push) begin
        wptr_q <= (wptr_q == PtrWidth'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrWidth'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the level unchanged
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= push_data_i;
    end
  end

  count_bound_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= CntWidth'(Depth));

  // Head entry must not move under a stalled consumer
  pop_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_valid_o && !pop_ready_i |=> pop_valid_o && $stable(pop_data_o));

endmodule

/* verilog/i2c_standby_flow.sv */
// Target-mode transfer FSM turning bus events into queue traffic and TX dwords into bus bytes
module i2c_standby_flow (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                acq_valid_i,
  input  i2c_tti_pkg::acq_evt_t               acq_evt_i,
  output logic                                acq_ready_o,
  input  logic                                cmd_valid_i,
  input  i2c_tti_pkg::cmd_desc_t              cmd_i,
  output logic                                cmd_ready_o,
  input  logic                                tx_valid_i,
  input  logic [i2c_tti_pkg::DwordWidth-1:0]  tx_dword_i,
  output logic                                tx_ready_o,
  output logic                                bus_tx_valid_o,
  output logic [7:0]                          bus_tx_byte_o,
  input  logic                                bus_tx_ready_i,
  output logic                                rx_valid_o,
  output logic [i2c_tti_pkg::DwordWidth-1:0]  rx_dword_o,
  input  logic                                rx_ready_i,
  output logic                                resp_valid_o,
  output i2c_tti_pkg::resp_desc_t             resp_o,
  input  logic                                resp_ready_i,
  output logic                                err_o
);

  typedef enum logic [3:0] {
    AwaitStart   = 4'd0,
    ReceiveByte  = 4'd1,
    PushDword    = 4'd2,
    PushResponse = 4'd3,
    PopCommand   = 4'd4,
    PopDword     = 4'd5,
    SendByte     = 4'd6,
    ReportError  = 4'd7,
    AwaitStop    = 4'd8
  } state_e;

  state_e state_q, state_d;
  logic   live_q;

  // Dword being assembled on writes or unpacked on reads
  logic [i2c_tti_pkg::DwordWidth-1:0] dword_q;
  logic [i2c_tti_pkg::LenWidth-1:0]   byte_cnt_q;
  logic [i2c_tti_pkg::LenWidth-1:0]   read_len_q;
  logic [i2c_tti_pkg::TidWidth-1:0]   tid_q;
  i2c_tti_pkg::resp_err_e             err_q;

  // Bus already closed the transfer with STOP or restart
  logic closing_q;
  logic restart_q;
  logic rnw_q;
  // Forces an idle cycle between bus bytes
  logic gap_q;

  logic [1:0] lane;
  logic evt_fire;
  logic is_start, is_restart, is_stop, is_data, is_nack, is_close;
  logic read_abort;
  logic cmd_fire, tx_fire, rx_fire, resp_fire, bus_fire;
  logic begin_xfer, begin_rnw;

  assign lane = byte_cnt_q[1:0];

  assign acq_ready_o = live_q & (state_q != PushDword) & (state_q != PushResponse);
  assign evt_fire    = acq_valid_i & acq_ready_o;

  assign is_start   = evt_fire & (acq_evt_i.id == i2c_tti_pkg::AcqStart);
  assign is_restart = evt_fire & (acq_evt_i.id == i2c_tti_pkg::AcqRestart);
  assign is_stop    = evt_fire & (acq_evt_i.id == i2c_tti_pkg::AcqStop);
  assign is_data    = evt_fire & (acq_evt_i.id == i2c_tti_pkg::AcqData);
  assign is_nack    = evt_fire & (acq_evt_i.id == i2c_tti_pkg::AcqNack);
  assign is_close   = is_stop | is_restart;

  // Any of these before the read length is reached aborts the read
  assign read_abort = is_data | is_nack | is_close;

  assign cmd_ready_o    = (state_q == PopCommand);
  assign tx_ready_o     = (state_q == PopDword);
  assign rx_valid_o     = (state_q == PushDword);
  assign resp_valid_o   = (state_q == PushResponse);
  assign bus_tx_valid_o = (state_q == SendByte) & ~gap_q;
  assign err_o          = (state_q == ReportError);

  assign cmd_fire  = cmd_valid_i & cmd_ready_o;
  assign tx_fire   = tx_valid_i & tx_ready_o;
  assign rx_fire   = rx_valid_o & rx_ready_i;
  assign resp_fire = resp_valid_o & resp_ready_i;
  assign bus_fire  = bus_tx_valid_o & bus_tx_ready_i;

  assign bus_tx_byte_o = dword_q[{lane, 3'b000} +: 8];
  assign rx_dword_o    = dword_q;

  assign resp_o = '{err_status: err_q, tid: tid_q, data_length: byte_cnt_q};

  always_comb begin
    state_d    = state_q;
    begin_xfer = 1'b0;
    begin_rnw  = 1'b0;
    unique case (state_q)
      AwaitStart: begin
        if (is_start || is_restart) begin
          begin_xfer = 1'b1;
          begin_rnw  = acq_evt_i.data[0];
        end
      end
      ReceiveByte: begin
        // Pending partial dword goes out before the response
        if (is_close) begin
          state_d = (lane != 2'd0) ? PushDword : PushResponse;
        end else if (is_data && lane == 2'd3) begin
          state_d = PushDword;
        end
      end
      PushDword: begin
        if (rx_fire) begin
          state_d = closing_q ? PushResponse : ReceiveByte;
        end
      end
      PushResponse: begin
        if (resp_fire) begin
          if (!closing_q) begin
            state_d = AwaitStop;
          end else if (restart_q) begin
            begin_xfer = 1'b1;
            begin_rnw  = rnw_q;
          end else begin
            state_d = AwaitStart;
          end
        end
      end
      PopCommand: begin
        if (read_abort) begin
          state_d = ReportError;
        end else if (cmd_fire) begin
          state_d = (cmd_i.data_length == '0) ? ReportError : PopDword;
        end
      end
      PopDword: begin
        if (read_abort) begin
          state_d = ReportError;
        end else if (tx_fire) begin
          state_d = SendByte;
        end
      end
      SendByte: begin
        if (read_abort) begin
          state_d = ReportError;
        end else if (bus_fire) begin
          if (byte_cnt_q + 1'b1 == read_len_q) begin
            state_d = AwaitStop;
          end else if (lane == 2'd3) begin
            state_d = PopDword;
          end
        end
      end
      ReportError: begin
        state_d = PushResponse;
      end
      AwaitStop: begin
        // Aborted transfers have already responded
        if (err_q == i2c_tti_pkg::RespAborted) begin
          if (is_stop) begin
            state_d = AwaitStart;
          end else if (is_restart) begin
            begin_xfer = 1'b1;
            begin_rnw  = acq_evt_i.data[0];
          end
        end else if (is_close) begin
          state_d = PushResponse;
        end
      end
      default: begin
        state_d = AwaitStart;
      end
    endcase
    if (begin_xfer) begin
      state_d = begin_rnw ? PopCommand : ReceiveByte;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= AwaitStart;
      live_q     <= 1'b0;
      byte_cnt_q <= '0;
      read_len_q <= '0;
      tid_q      <= '0;
      err_q      <= i2c_tti_pkg::RespSuccess;
      closing_q  <= 1'b0;
      restart_q  <= 1'b0;
      rnw_q      <= 1'b0;
      gap_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      live_q  <= 1'b1;
      gap_q   <= bus_fire;
      if (begin_xfer) begin
        byte_cnt_q <= '0;
        tid_q      <= '0;
        err_q      <= i2c_tti_pkg::RespSuccess;
        closing_q  <= 1'b0;
        restart_q  <= 1'b0;
      end else begin
        if (is_close && state_q != AwaitStart) begin
          closing_q <= 1'b1;
          restart_q <= is_restart;
          rnw_q     <= acq_evt_i.data[0];
        end
        if ((state_q == ReceiveByte && is_data) || bus_fire) begin
          byte_cnt_q <= byte_cnt_q + 1'b1;
        end
        if (cmd_fire) begin
          read_len_q <= cmd_i.data_length;
          tid_q      <= cmd_i.tid;
        end
        if (state_q == ReportError) begin
          err_q <= i2c_tti_pkg::RespAborted;
        end
      end
    end
  end

  // Write bytes land in their little-endian lane, reads load a whole dword
  always_ff @(posedge clk_i) begin
    if (begin_xfer || rx_fire) begin
      dword_q <= '0;
    end else if (state_q == ReceiveByte && is_data) begin
      dword_q[{lane, 3'b000} +: 8] <= acq_evt_i.data;
    end else if (tx_fire) begin
      dword_q <= tx_dword_i;
    end
  end

  state_legal_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {AwaitStart, ReceiveByte, PushDword, PushResponse, PopCommand,
                    PopDword, SendByte, ReportError, AwaitStop});

  // Error is a single pulse and the aborted response is offered right after it
  err_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_o |=> !err_o && resp_valid_o && resp_o.err_status == i2c_tti_pkg::RespAborted);

endmodule

/* verilog/i2c_tti_bridge.sv */
// Top level of the I2C target standby bridge with four host queues and the transfer FSM
module i2c_tti_bridge #(
  parameter int CmdDepth  = 4,
  parameter int RespDepth = 4,
  parameter int TxDepth   = 8,
  parameter int RxDepth   = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Bus engine side
  input  logic                                acq_valid_i,
  input  i2c_tti_pkg::acq_evt_t               acq_evt_i,
  output logic                                acq_ready_o,
  output logic                                bus_tx_valid_o,
  output logic [7:0]                          bus_tx_byte_o,
  input  logic                                bus_tx_ready_i,
  // Host side
  input  logic                                cmd_valid_i,
  input  i2c_tti_pkg::cmd_desc_t              cmd_i,
  output logic                                cmd_ready_o,
  input  logic                                tx_valid_i,
  input  logic [i2c_tti_pkg::DwordWidth-1:0]  tx_dword_i,
  output logic                                tx_ready_o,
  output logic                                rx_valid_o,
  output logic [i2c_tti_pkg::DwordWidth-1:0]  rx_dword_o,
  input  logic                                rx_ready_i,
  output logic                                resp_valid_o,
  output i2c_tti_pkg::resp_desc_t             resp_o,
  input  logic                                resp_ready_i,
  output logic                                err_o
);

  // Queue sides facing the flow
  logic                               cmd_q_valid, cmd_q_ready;
  i2c_tti_pkg::cmd_desc_t             cmd_q_data;
  logic                               tx_q_valid, tx_q_ready;
  logic [i2c_tti_pkg::DwordWidth-1:0] tx_q_data;
  logic                               rx_q_valid, rx_q_ready;
  logic [i2c_tti_pkg::DwordWidth-1:0] rx_q_data;
  logic                               resp_q_valid, resp_q_ready;
  i2c_tti_pkg::resp_desc_t            resp_q_data;

  tti_queue #(
    .Width($bits(i2c_tti_pkg::cmd_desc_t)),
    .Depth(CmdDepth)
  ) u_cmd_q (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_valid_i(cmd_valid_i),
    .push_data_i (cmd_i),
    .push_ready_o(cmd_ready_o),
    .pop_valid_o (cmd_q_valid),
    .pop_data_o  (cmd_q_data),
    .pop_ready_i (cmd_q_ready)
  );

  tti_queue #(
    .Width($bits(i2c_tti_pkg::resp_desc_t)),
    .Depth(RespDepth)
  ) u_resp_q (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_valid_i(resp_q_valid),
    .push_data_i (resp_q_data),
    .push_ready_o(resp_q_ready),
    .pop_valid_o (resp_valid_o),
    .pop_data_o  (resp_o),
    .pop_ready_i (resp_ready_i)
  );

  tti_queue #(
    .Width(i2c_tti_pkg::DwordWidth),
    .Depth(TxDepth)
  ) u_tx_q (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_valid_i(tx_valid_i),
    .push_data_i (tx_dword_i),
    .push_ready_o(tx_ready_o),
    .pop_valid_o (tx_q_valid),
    .pop_data_o  (tx_q_data),
    .pop_ready_i (tx_q_ready)
  );

  tti_queue #(
    .Width(i2c_tti_pkg::DwordWidth),
    .Depth(RxDepth)
  ) u_rx_q (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_valid_i(rx_q_valid),
    .push_data_i (rx_q_data),
    .push_ready_o(rx_q_ready),
    .pop_valid_o (rx_valid_o),
    .pop_data_o  (rx_dword_o),
    .pop_ready_i (rx_ready_i)
  );

  i2c_standby_flow u_flow (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .acq_valid_i   (acq_valid_i),
    .acq_evt_i     (acq_evt_i),
    .acq_ready_o   (acq_ready_o),
    .cmd_valid_i   (cmd_q_valid),
    .cmd_i         (cmd_q_data),
    .cmd_ready_o   (cmd_q_ready),
    .tx_valid_i    (tx_q_valid),
    .tx_dword_i    (tx_q_data),
    .tx_ready_o    (tx_q_ready),
    .bus_tx_valid_o(bus_tx_valid_o),
    .bus_tx_byte_o (bus_tx_byte_o),
    .bus_tx_ready_i(bus_tx_ready_i),
    .rx_valid_o    (rx_q_valid),
    .rx_dword_o    (rx_q_data),
    .rx_ready_i    (rx_q_ready),
    .resp_valid_o  (resp_q_valid),
    .resp_o        (resp_q_data),
    .resp_ready_i  (resp_q_ready),
    .err_o         (err_o)
  );

endmodule

/* test/tb_i2c_tti_tasks.svh */
// Bus event and host queue stimulus tasks, xorshift random source and bounded wait loops
`ifndef TB_I2C_TTI_TASKS_SVH
`define TB_I2C_TTI_TASKS_SVH

localparam int WaitLimit = 500;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic logic [31:0] random_dword();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

function automatic logic [7:0] random_byte();
  rng_state = xorshift32(rng_state);
  return rng_state[7:0];
endfunction

task automatic stop_with_failure(input string reason);
  $display("%s", reason);
  $display("Testbench failed");
  $fatal(1);
endtask

// All driving happens 2 time units after the rising edge
task automatic next_cycle();
  @(posedge clk_i);
  #2;
endtask

task automatic send_event(input i2c_tti_pkg::acq_id_e id, input logic [7:0] data);
  int waited;
  waited         = 0;
  acq_valid_i    = 1'b1;
  acq_evt_i.id   = id;
  acq_evt_i.data = data;
  while (!acq_ready_o && waited < WaitLimit) begin
    next_cycle();
    waited++;
  end
  if (!acq_ready_o) begin
    stop_with_failure("Timeout waiting for acq_ready_o");
  end else begin
    next_cycle();
    acq_valid_i = 1'b0;
  end
endtask

task automatic push_cmd(input logic [3:0] tid, input logic [15:0] len);
  int waited;
  waited          = 0;
  cmd_valid_i     = 1'b1;
  cmd_i.tid       = tid;
  cmd_i.data_length = len;
  while (!cmd_ready_o && waited < WaitLimit) begin
    next_cycle();
    waited++;
  end
  if (!cmd_ready_o) begin
    stop_with_failure("Timeout waiting for cmd_ready_o");
  end else begin
    next_cycle();
    cmd_valid_i = 1'b0;
  end
endtask

task automatic push_tx(input logic [31:0] word);
  int waited;
  waited     = 0;
  tx_valid_i = 1'b1;
  tx_dword_i = word;
  while (!tx_ready_o && waited < WaitLimit) begin
    next_cycle();
    waited++;
  end
  if (!tx_ready_o) begin
    stop_with_failure("Timeout waiting for tx_ready_o");
  end else begin
    next_cycle();
    tx_valid_i = 1'b0;
  end
endtask

// Accepts exactly count bytes from the bus side, then drops ready
task automatic take_bus_bytes(input int count);
  int taken;
  int waited;
  taken          = 0;
  waited         = 0;
  bus_tx_ready_i = 1'b1;
  while (taken < count && waited < WaitLimit) begin
    if (bus_tx_valid_o) begin
      taken++;
    end
    next_cycle();
    waited++;
  end
  bus_tx_ready_i = 1'b0;
  if (taken < count) begin
    stop_with_failure("Timeout waiting for bus_tx_valid_o");
  end
endtask

task automatic wait_rx_drained();
  int waited;
  waited = 0;
  while (rx_head != rx_tail && waited < WaitLimit) begin
    next_cycle();
    waited++;
  end
  if (rx_head != rx_tail) begin
    stop_with_failure("Timeout waiting for rx_valid_o");
  end
endtask

task automatic wait_resp_drained();
  int waited;
  waited = 0;
  while (resp_head != resp_tail && waited < WaitLimit) begin
    next_cycle();
    waited++;
  end
  if (resp_head != resp_tail) begin
    stop_with_failure("Timeout waiting for resp_valid_o");
  end
endtask

// Offers STOP while the RX queue is full and requires the bus side to stay stalled
task automatic hold_stop_while_full(input int cycles);
  acq_valid_i    = 1'b1;
  acq_evt_i.id   = i2c_tti_pkg::AcqStop;
  acq_evt_i.data = 8'h00;
  repeat (cycles) begin
    assert (!acq_ready_o)
      else stop_with_failure($sformatf("FAILED at %0t: acq_ready_o high with RX queue full",
                                       $time));
    next_cycle();
  end
endtask

`endif

/* test/tb_i2c_tti_bridge.sv */
// Testbench for the I2C target standby bridge with scoreboards, checking assertions and tests
module tb_i2c_tti_bridge;

  localparam int         RxDepth    = 4;
  localparam int         SbDepth    = 32;
  localparam logic [6:0] TargetAddr = 7'h42;

  logic                                 clk_i = 1'b0;
  logic                                 rst_ni;
  logic                                 acq_valid_i;
  i2c_tti_pkg::acq_evt_t                acq_evt_i;
  logic                                 acq_ready_o;
  logic                                 bus_tx_valid_o;
  logic [7:0]                           bus_tx_byte_o;
  logic                                 bus_tx_ready_i;
  logic                                 cmd_valid_i;
  i2c_tti_pkg::cmd_desc_t               cmd_i;
  logic                                 cmd_ready_o;
  logic                                 tx_valid_i;
  logic [i2c_tti_pkg::DwordWidth-1:0]   tx_dword_i;
  logic                                 tx_ready_o;
  logic                                 rx_valid_o;
  logic [i2c_tti_pkg::DwordWidth-1:0]   rx_dword_o;
  logic                                 rx_ready_i;
  logic                                 resp_valid_o;
  i2c_tti_pkg::resp_desc_t              resp_o;
  logic                                 resp_ready_i;
  logic                                 err_o;

  logic [31:0] rng_state;

  // Scoreboard heads advance on accepted outputs and tails on new expectations
  logic [31:0]             exp_rx_mem   [SbDepth];
  logic [7:0]              exp_byte_mem [SbDepth];
  i2c_tti_pkg::resp_desc_t exp_resp_mem [SbDepth];
  int rx_head = 0;
  int rx_tail = 0;
  int byte_head = 0;
  int byte_tail = 0;
  int resp_head = 0;
  int resp_tail = 0;
  int err_seen = 0;
  int err_budget = 0;

  `include "tb_i2c_tti_tasks.svh"

  always #10 clk_i = ~clk_i;

  i2c_tti_bridge #(
    .CmdDepth (4),
    .RespDepth(4),
    .TxDepth  (8),
    .RxDepth  (RxDepth)
  ) UUT (.*);

  always @(posedge clk_i) begin
    if (rx_valid_o && rx_ready_i) begin
      rx_head <= rx_head + 1;
    end
    if (bus_tx_valid_o && bus_tx_ready_i) begin
      byte_head <= byte_head + 1;
    end
    if (resp_valid_o && resp_ready_i) begin
      resp_head <= resp_head + 1;
    end
    if (err_o) begin
      err_seen <= err_seen + 1;
    end
  end

  rx_match_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rx_valid_o && rx_ready_i) |-> (rx_head != rx_tail && rx_dword_o == exp_rx_mem[rx_head]))
    else stop_with_failure($sformatf("FAILED at %0t: RX dword %08h, expected %08h",
                                     $time, rx_dword_o, exp_rx_mem[rx_head]));

  bus_match_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bus_tx_valid_o && bus_tx_ready_i) |->
      (byte_head != byte_tail && bus_tx_byte_o == exp_byte_mem[byte_head]))
    else stop_with_failure($sformatf("FAILED at %0t: bus byte %02h, expected %02h",
                                     $time, bus_tx_byte_o, exp_byte_mem[byte_head]));

  resp_match_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (resp_valid_o && resp_ready_i) |->
      (resp_head != resp_tail && resp_o == exp_resp_mem[resp_head]))
    else stop_with_failure($sformatf("FAILED at %0t: response %p, expected %p",
                                     $time, resp_o, exp_resp_mem[resp_head]));

  // Error pulses are only allowed where a test expects one
  err_budget_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_o |-> err_seen < err_budget)
    else stop_with_failure($sformatf("FAILED at %0t: unexpected err_o pulse", $time));

  task automatic expect_dword(input logic [31:0] word);
    exp_rx_mem[rx_tail] = word;
    rx_tail++;
  endtask

  task automatic expect_byte(input logic [7:0] value);
    exp_byte_mem[byte_tail] = value;
    byte_tail++;
  endtask

  task automatic expect_resp(input i2c_tti_pkg::resp_err_e err, input logic [3:0] tid,
                             input logic [15:0] len);
    exp_resp_mem[resp_tail].err_status  = err;
    exp_resp_mem[resp_tail].tid         = tid;
    exp_resp_mem[resp_tail].data_length = len;
    resp_tail++;
  endtask

  task automatic check_err_count();
    assert (err_seen == err_budget)
      else stop_with_failure($sformatf("FAILED at %0t: %0d err_o pulses, expected %0d",
                                       $time, err_seen, err_budget));
  endtask

  // Write transfer of random bytes, packed little-endian with zero padding
  task automatic write_transfer(input int count, input bit stall_rx);
    logic [31:0] word;
    logic [7:0]  value;
    int          i;
    word = '0;
    send_event(i2c_tti_pkg::AcqStart, {TargetAddr, 1'b0});
    for (i = 0; i < count; i++) begin
      value = random_byte();
      word[8*(i%4) +: 8] = value;
      if (i % 4 == 3) begin
        expect_dword(word);
        word = '0;
      end
      send_event(i2c_tti_pkg::AcqData, value);
    end
    if (count % 4 != 0) begin
      expect_dword(word);
    end
    expect_resp(i2c_tti_pkg::RespSuccess, 4'd0, 16'(count));
    if (stall_rx) begin
      hold_stop_while_full(8);
      rx_ready_i = 1'b1;
    end
    send_event(i2c_tti_pkg::AcqStop, 8'h00);
    wait_rx_drained();
    wait_resp_drained();
  endtask

  initial begin : test_sequence
    logic [31:0] d0;
    logic [31:0] d1;
    int          i;
    rng_state      = 32'h17a3;
    rst_ni         = 1'b0;
    acq_valid_i    = 1'b0;
    acq_evt_i      = '0;
    bus_tx_ready_i = 1'b0;
    cmd_valid_i    = 1'b0;
    cmd_i          = '0;
    tx_valid_i     = 1'b0;
    tx_dword_i     = '0;
    rx_ready_i     = 1'b1;
    resp_ready_i   = 1'b1;
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // First cycle out of reset
    assert (!rx_valid_o && !resp_valid_o && !bus_tx_valid_o && !err_o &&
            !acq_ready_o && !cmd_ready_o && !tx_ready_o)
      else stop_with_failure($sformatf("FAILED at %0t: output active right after reset", $time));
    next_cycle();

    write_transfer(7, 1'b0);

    // Read of 6 bytes from two TX dwords
    d0 = random_dword();
    d1 = random_dword();
    push_cmd(4'd5, 16'd6);
    push_tx(d0);
    push_tx(d1);
    for (i = 0; i < 4; i++) begin
      expect_byte(d0[8*i +: 8]);
    end
    for (i = 0; i < 2; i++) begin
      expect_byte(d1[8*i +: 8]);
    end
    expect_resp(i2c_tti_pkg::RespSuccess, 4'd5, 16'd6);
    send_event(i2c_tti_pkg::AcqStart, {TargetAddr, 1'b1});
    take_bus_bytes(6);
    send_event(i2c_tti_pkg::AcqNack, 8'h00);
    send_event(i2c_tti_pkg::AcqStop, 8'h00);
    wait_resp_drained();

    // Host stops popping so the RX queue fills during a 20-byte write
    rx_ready_i = 1'b0;
    write_transfer(20, 1'b1);

    // Zero-length read aborts
    push_cmd(4'd3, 16'd0);
    err_budget = err_budget + 1;
    expect_resp(i2c_tti_pkg::RespAborted, 4'd3, 16'd0);
    send_event(i2c_tti_pkg::AcqStart, {TargetAddr, 1'b1});
    wait_resp_drained();
    send_event(i2c_tti_pkg::AcqStop, 8'h00);
    check_err_count();
    write_transfer(5, 1'b0);

    // Controller NACKs after 2 of 4 read bytes
    d0 = random_dword();
    push_cmd(4'd6, 16'd4);
    push_tx(d0);
    expect_byte(d0[7:0]);
    expect_byte(d0[15:8]);
    err_budget = err_budget + 1;
    expect_resp(i2c_tti_pkg::RespAborted, 4'd6, 16'd2);
    send_event(i2c_tti_pkg::AcqStart, {TargetAddr, 1'b1});
    take_bus_bytes(2);
    send_event(i2c_tti_pkg::AcqNack, 8'h00);
    wait_resp_drained();
    send_event(i2c_tti_pkg::AcqStop, 8'h00);
    check_err_count();

    repeat (4) next_cycle();
    if (rx_head != rx_tail || byte_head != byte_tail || resp_head != resp_tail) begin
      stop_with_failure("Expected outputs never arrived before the end of the run");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

/* i2c_tti_bridge.f */
+incdir+test
verilog/i2c_tti_pkg.sv
verilog/tti_queue.sv
verilog/i2c_standby_flow.sv
verilog/i2c_tti_bridge.sv
test/tb_i2c_tti_bridge.sv

/* Makefile */
# Verilator build and run for the I2C target standby bridge

VERILATOR ?= verilator
TOP       ?= tb_i2c_tti_bridge
FILELIST  ?= i2c_tti_bridge.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Testbench passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only when the pass message shows up in the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fq "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
